// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int xlen      = 32;
  localparam int rob_tag_w = 4;

  typedef logic [xlen-1:0]      addr_t;
  typedef logic [xlen-1:0]      data_t;
  typedef logic [rob_tag_w-1:0] rob_tag_t;

  // a load waiting in the load station
  typedef struct packed {
    addr_t    addr;
    rob_tag_t tag;
  } load_req_t;

  typedef struct packed {
    addr_t          addr;
    data_t          data;
    logic [xlen/8-1:0] wmask;  // one bit per byte lane
    rob_tag_t       tag;
  } store_req_t;

  typedef struct packed {
    addr_t             addr;
    data_t             wdata;
    logic [xlen/8-1:0] wmask;
    logic              we;  // high for a write, low for a read
  } dmem_req_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    data_t    rdata;  // raw word, no byte extraction here
  } load_done_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
  } store_done_t;

  typedef enum logic [1:0] {
    idle,
    load_wait,
    store_wait
  } arb_state_t;

endpackage

`default_nettype wire

// File: design/load_rs.sv
`timescale 1ns/1ps
`default_nettype none

module load_rs #(
  parameter int depth = 3
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               flush,

  input  wire logic               alloc,
  input  wire lsu_pkg::load_req_t alloc_entry,
  output logic                    full,

  output logic                    pending,
  output logic [depth-1:0]        sel_idx,
  output lsu_pkg::load_req_t      sel_entry,

  input  wire logic               pop,
  input  wire logic [depth-1:0]   pop_idx
);

  logic [depth-1:0]   valid;
  lsu_pkg::load_req_t slots [depth];

  logic [depth-1:0]   free_oh;
  logic [depth-1:0]   pop_mask;
  logic               alloc_ok;

  // lowest set bit of valid is the oldest-index choice offered to the arbiter
  assign sel_idx = valid & (~valid + 1'b1);

  // lowest clear bit, zero when every slot is taken
  assign free_oh = ~valid & (valid + 1'b1);

  assign full     = &valid;
  assign pending  = |valid;
  assign alloc_ok = alloc && !full;
  assign pop_mask = {depth{pop}} & pop_idx;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid <= '0;
    end else begin
      valid <= (valid & ~pop_mask) | ({depth{alloc_ok}} & free_oh);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (alloc_ok && free_oh[i]) begin
        slots[i] <= alloc_entry;
      end
    end
  end

  // sel_idx is one-hot, so at most one slot matches
  always_comb begin
    sel_entry = '0;
    for (int i = 0; i < depth; i++) begin
      if (sel_idx[i]) begin
        sel_entry = slots[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/store_rs.sv
`timescale 1ns/1ps
`default_nettype none

module store_rs #(
  parameter int depth = 4
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                flush,

  input  wire logic                alloc,
  input  wire lsu_pkg::store_req_t alloc_entry,
  output logic                     full,

  output logic                     pending,
  output lsu_pkg::store_req_t      head_entry,

  input  wire logic                pop
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  lsu_pkg::store_req_t queue [depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             alloc_ok;
  logic             pop_ok;

  // depth need not be a power of two
  function automatic logic [ptr_w-1:0] wrap_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full       = (count == cnt_w'(depth));
  assign pending    = (count != '0);
  assign head_entry = queue[head];  // oldest store, program order
  assign alloc_ok   = alloc && !full;
  assign pop_ok     = pop && pending;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc_ok) begin
        tail <= wrap_inc(tail);
      end
      if (pop_ok) begin
        head <= wrap_inc(head);
      end
      count <= count + cnt_w'(alloc_ok) - cnt_w'(pop_ok);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_ok) begin
      queue[tail] <= alloc_entry;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_arbiter_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_fsm #(
  parameter int load_rs_depth = 3
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     flush,

  input  wire logic                     load_pending,
  input  wire logic                     store_pending,
  input  wire logic [load_rs_depth-1:0] load_idx,
  input  wire lsu_pkg::load_req_t       load_entry,
  input  wire lsu_pkg::store_req_t      store_entry,

  output logic                          load_pop,
  output logic [load_rs_depth-1:0]      load_pop_idx,
  output logic                          store_pop,

  output logic                          dmem_req_valid,
  output lsu_pkg::dmem_req_t            dmem_req,
  input  wire logic                     dmem_resp,
  input  wire lsu_pkg::data_t           dmem_rdata,

  output lsu_pkg::load_done_t           load_done,
  output lsu_pkg::store_done_t          store_done
);

  lsu_pkg::arb_state_t state;
  lsu_pkg::arb_state_t state_next;

  logic [load_rs_depth-1:0] inflight_idx;
  lsu_pkg::rob_tag_t        inflight_tag;
  logic                     grant_load;
  logic                     grant_store;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      state <= lsu_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // the slot index may shift under a newer lower-index load, so latch it at grant
  always_ff @(posedge clk) begin
    if (grant_load) begin
      inflight_idx <= load_idx;
      inflight_tag <= load_entry.tag;
    end
  end

  always_comb begin
    state_next   = state;
    grant_load   = 1'b0;
    grant_store  = 1'b0;
    load_pop     = 1'b0;
    load_pop_idx = '0;
    store_pop    = 1'b0;
    load_done    = '0;
    store_done   = '0;

    case (state)
      lsu_pkg::idle: begin
        if (!flush && store_pending) begin
          grant_store = 1'b1;  // stores win over loads
        end else if (!flush && load_pending) begin
          grant_load = 1'b1;
        end
      end
      lsu_pkg::load_wait: begin
        if (dmem_resp) begin
          load_pop        = 1'b1;
          load_pop_idx    = inflight_idx;
          load_done.valid = !flush;  // a flushed access is not reported
          load_done.tag   = inflight_tag;
          load_done.rdata = dmem_rdata;
          state_next      = lsu_pkg::idle;
          grant_store     = !flush && store_pending;
        end
      end
      lsu_pkg::store_wait: begin
        if (dmem_resp) begin
          store_pop        = 1'b1;
          // head has not moved while the store was out
          store_done.valid = !flush;
          store_done.tag   = store_entry.tag;
          state_next       = lsu_pkg::idle;
          grant_load       = !flush && load_pending;
        end
      end
      default: begin
        state_next = lsu_pkg::idle;
      end
    endcase

    if (grant_store) begin
      state_next = lsu_pkg::store_wait;
    end else if (grant_load) begin
      state_next = lsu_pkg::load_wait;
    end
  end

  assign dmem_req_valid = grant_store || grant_load;

  always_comb begin
    if (grant_store) begin
      dmem_req.addr  = store_entry.addr;
      dmem_req.wdata = store_entry.data;
      dmem_req.wmask = store_entry.wmask;
      dmem_req.we    = 1'b1;
    end else begin
      dmem_req.addr  = load_entry.addr;  // reads carry no data and no mask
      dmem_req.wdata = '0;
      dmem_req.wmask = '0;
      dmem_req.we    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit #(
  parameter int load_rs_depth  = 3,
  parameter int store_rs_depth = 4
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                flush,

  input  wire logic                load_alloc,
  input  wire lsu_pkg::load_req_t  load_alloc_entry,
  output logic                     load_full,

  input  wire logic                store_alloc,
  input  wire lsu_pkg::store_req_t store_alloc_entry,
  output logic                     store_full,

  output logic                     dmem_req_valid,
  output lsu_pkg::dmem_req_t       dmem_req,
  input  wire logic                dmem_resp,
  input  wire lsu_pkg::data_t      dmem_rdata,

  output lsu_pkg::load_done_t      load_done,
  output lsu_pkg::store_done_t     store_done
);

  logic                     load_pending;
  logic [load_rs_depth-1:0] load_idx;
  lsu_pkg::load_req_t       load_entry;
  logic                     load_pop;
  logic [load_rs_depth-1:0] load_pop_idx;

  logic                     store_pending;
  lsu_pkg::store_req_t      store_entry;
  logic                     store_pop;

  load_rs #(
    .depth(load_rs_depth)
  ) u_load_rs (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .alloc      (load_alloc),
    .alloc_entry(load_alloc_entry),
    .full       (load_full),
    .pending    (load_pending),
    .sel_idx    (load_idx),
    .sel_entry  (load_entry),
    .pop        (load_pop),
    .pop_idx    (load_pop_idx)
  );

  store_rs #(
    .depth(store_rs_depth)
  ) u_store_rs (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .alloc      (store_alloc),
    .alloc_entry(store_alloc_entry),
    .full       (store_full),
    .pending    (store_pending),
    .head_entry (store_entry),
    .pop        (store_pop)
  );

  mem_arbiter_fsm #(
    .load_rs_depth(load_rs_depth)
  ) u_mem_arbiter_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .load_pending  (load_pending),
    .store_pending (store_pending),
    .load_idx      (load_idx),
    .load_entry    (load_entry),
    .store_entry   (store_entry),
    .load_pop      (load_pop),
    .load_pop_idx  (load_pop_idx),
    .store_pop     (store_pop),
    .dmem_req_valid(dmem_req_valid),
    .dmem_req      (dmem_req),
    .dmem_resp     (dmem_resp),
    .dmem_rdata    (dmem_rdata),
    .load_done     (load_done),
    .store_done    (store_done)
  );

endmodule

`default_nettype wire

// File: tb/dmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_model (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               req_valid,
  input  wire lsu_pkg::dmem_req_t req,
  output logic                    resp,
  output lsu_pkg::data_t          rdata,
  output logic                    busy
);

  lsu_pkg::data_t     mem [256];
  lsu_pkg::dmem_req_t cur;
  lsu_pkg::data_t     word;
  logic [31:0]        rng;
  logic               active;
  int                 lat_left;

  function automatic logic [31:0] step_rng(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic lsu_pkg::data_t fill_word(input int i);
    logic [7:0] a;
    a = 8'(i);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  always @(posedge clk) begin
    resp <= 1'b0;
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_word(i);
      end
      rng      = 32'd36905;
      active   = 1'b0;
      lat_left = 0;
      busy     <= 1'b0;
      rdata    <= '0;
    end else begin
      if (req_valid) begin
        cur      = req;
        rng      = step_rng(rng);
        lat_left = int'(rng[1:0]) + 1;  // response 1 to 4 cycles after the request
        active   = 1'b1;
      end
      if (active) begin
        lat_left = lat_left - 1;
        if (lat_left == 0) begin
          active = 1'b0;
          resp   <= 1'b1;
          word   = mem[cur.addr[9:2]];
          if (cur.we) begin
            for (int b = 0; b < 4; b++) begin
              if (cur.wmask[b]) begin
                word[8*b +: 8] = cur.wdata[8*b +: 8];
              end
            end
            mem[cur.addr[9:2]] <= word;
          end else begin
            rdata <= word;
          end
        end
      end
      busy <= active;  // high while a request waits for its response
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit;

  localparam int load_depth  = 3;
  localparam int store_depth = 4;
  localparam int max_cycles  = 4000;  // about 70 requests, each well under 10 cycles

  logic                 clk;
  logic                 rst_n;
  logic                 flush;
  logic                 load_alloc;
  lsu_pkg::load_req_t   load_alloc_entry;
  logic                 load_full;
  logic                 store_alloc;
  lsu_pkg::store_req_t  store_alloc_entry;
  logic                 store_full;
  logic                 dmem_req_valid;
  lsu_pkg::dmem_req_t   dmem_req;
  logic                 dmem_resp;
  lsu_pkg::data_t       dmem_rdata;
  logic                 dmem_busy;
  lsu_pkg::load_done_t  load_done;
  lsu_pkg::store_done_t store_done;

  lsu_pkg::data_t    ref_mem [256];
  lsu_pkg::data_t    load_exp [16];
  logic [15:0]       load_busy;
  logic [15:0]       store_busy;
  logic [31:0]       rng;
  logic [3:0]        next_tag;
  int                errors;
  int                checks;
  int                tests;
  int                cycles;
  int                loads_out;
  int                stores_out;
  int                loads_done_cnt;
  int                done_pulses;
  int                load_cnt;
  int                store_cnt;
  int                full_rises;
  int                req_pulses;
  int                resp_pulses;
  logic              outstanding;
  logic              full_prev;
  logic              req_we_log [$];
  lsu_pkg::rob_tag_t last_load_tag;
  lsu_pkg::data_t    last_load_data;
  lsu_pkg::rob_tag_t last_store_tag;

  load_store_unit #(
    .load_rs_depth (load_depth),
    .store_rs_depth(store_depth)
  ) uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush            (flush),
    .load_alloc       (load_alloc),
    .load_alloc_entry (load_alloc_entry),
    .load_full        (load_full),
    .store_alloc      (store_alloc),
    .store_alloc_entry(store_alloc_entry),
    .store_full       (store_full),
    .dmem_req_valid   (dmem_req_valid),
    .dmem_req         (dmem_req),
    .dmem_resp        (dmem_resp),
    .dmem_rdata       (dmem_rdata),
    .load_done        (load_done),
    .store_done       (store_done)
  );

  dmem_model u_dmem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(dmem_req_valid),
    .req      (dmem_req),
    .resp     (dmem_resp),
    .rdata    (dmem_rdata),
    .busy     (dmem_busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // same contents as the memory holds after reset
  function automatic lsu_pkg::data_t initial_word(input int i);
    logic [7:0] a;
    a = 8'(i);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  function automatic lsu_pkg::data_t merge_bytes(input lsu_pkg::data_t old_word,
                                                 input lsu_pkg::data_t new_word,
                                                 input logic [3:0] mask);
    lsu_pkg::data_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic flag_problem(input string what);
    errors++;
    $display("%s", what);
  endtask

  // registers the expectation for a load and returns its entry
  task automatic book_load(input logic [9:0] addr, output lsu_pkg::load_req_t e);
    e.addr = 32'(addr);
    e.tag  = next_tag;
    load_exp[next_tag]  = ref_mem[addr[9:2]];
    load_busy[next_tag] = 1'b1;
    loads_out++;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic book_store(input logic [9:0] addr, input lsu_pkg::data_t data,
                            input logic [3:0] mask, output lsu_pkg::store_req_t e);
    e.addr  = 32'(addr);
    e.data  = data;
    e.wmask = mask;
    e.tag   = next_tag;
    ref_mem[addr[9:2]]   = merge_bytes(ref_mem[addr[9:2]], data, mask);
    store_busy[next_tag] = 1'b1;
    stores_out++;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic alloc_load(input logic [9:0] addr, output lsu_pkg::rob_tag_t tag);
    lsu_pkg::load_req_t e;
    @(negedge clk);
    while (load_full) begin
      @(negedge clk);
    end
    @(posedge clk);
    book_load(addr, e);
    tag = e.tag;
    load_alloc       <= 1'b1;
    load_alloc_entry <= e;
    @(posedge clk);
    load_alloc <= 1'b0;
  endtask

  task automatic alloc_store(input logic [9:0] addr, input lsu_pkg::data_t data,
                             input logic [3:0] mask, output lsu_pkg::rob_tag_t tag);
    lsu_pkg::store_req_t e;
    @(negedge clk);
    while (store_full) begin
      @(negedge clk);
    end
    @(posedge clk);
    book_store(addr, data, mask, e);
    tag = e.tag;
    store_alloc       <= 1'b1;
    store_alloc_entry <= e;
    @(posedge clk);
    store_alloc <= 1'b0;
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (loads_out != 0 || stores_out != 0 || dmem_busy) begin
      @(negedge clk);
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "failed");
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk);
    check("dmem_req_valid", dmem_req_valid, 0);
    check("load_pop", uut.load_pop, 0);
    check("store_pop", uut.store_pop, 0);
    check("load_done.valid", load_done.valid, 0);
    check("store_done.valid", store_done.valid, 0);
    check("load_pending", uut.load_pending, 0);
    check("store_pending", uut.store_pending, 0);
    check("load_full", load_full, 0);
    check("store_full", store_full, 0);
    end_test("reset state", err0);
  endtask

  task automatic store_then_load();
    int err0;
    lsu_pkg::rob_tag_t st;
    lsu_pkg::rob_tag_t lt;
    err0 = errors;
    alloc_store(10'h040, 32'hdeadbeef, 4'hf, st);
    wait_drained();
    check("store_done.tag", last_store_tag, st);
    alloc_load(10'h040, lt);
    wait_drained();
    check("load_done.tag", last_load_tag, lt);
    check("load_done.rdata", last_load_data, 32'hdeadbeef);
    end_test("store then load", err0);
  endtask

  task automatic partial_writes();
    int err0;
    lsu_pkg::rob_tag_t t;
    err0 = errors;
    alloc_store(10'h080, 32'h11223344, 4'hf, t);
    alloc_store(10'h084, 32'h55667788, 4'hf, t);
    alloc_store(10'h080, 32'haabbccdd, 4'b0001, t);
    alloc_store(10'h084, 32'h99aabbcc, 4'b1100, t);
    wait_drained();
    alloc_load(10'h080, t);
    alloc_load(10'h084, t);
    wait_drained();
    end_test("partial writes", err0);
  endtask

  task automatic store_priority();
    int err0;
    lsu_pkg::load_req_t  le;
    lsu_pkg::store_req_t se;
    err0 = errors;
    wait_drained();
    req_we_log.delete();
    @(posedge clk);
    book_load(10'h0c0, le);
    book_store(10'h0c4, 32'h0badf00d, 4'hf, se);
    load_alloc        <= 1'b1;
    load_alloc_entry  <= le;
    store_alloc       <= 1'b1;
    store_alloc_entry <= se;
    @(posedge clk);
    load_alloc  <= 1'b0;
    store_alloc <= 1'b0;
    wait_drained();
    check("dmem_req count", req_we_log.size(), 2);
    if (req_we_log.size() >= 2) begin
      check("first dmem_req.we", req_we_log[0], 1);
      check("second dmem_req.we", req_we_log[1], 0);
    end
    end_test("store priority", err0);
  endtask

  task automatic many_loads();
    int err0;
    int done0;
    int rises0;
    lsu_pkg::rob_tag_t t;
    err0   = errors;
    done0  = loads_done_cnt;
    rises0 = full_rises;
    for (int i = 0; i < 20; i++) begin
      rng = xorshift32(rng);
      alloc_load({8'(64 + int'(rng[5:0])), 2'b00}, t);
    end
    wait_drained();
    check("loads completed", loads_done_cnt - done0, 20);
    check("load_full rise seen", full_rises > rises0, 1);
    end_test("many loads", err0);
  endtask

  task automatic mixed_traffic();
    int err0;
    int req0;
    int resp0;
    lsu_pkg::rob_tag_t t;
    err0  = errors;
    req0  = req_pulses;
    resp0 = resp_pulses;
    for (int i = 0; i < 30; i++) begin
      rng = xorshift32(rng);
      if (rng[0]) begin
        alloc_store({8'(128 + int'(rng[5:1])), 2'b00}, xorshift32(rng ^ 32'h1234),
                    rng[11:8], t);
      end else begin
        alloc_load({8'(192 + int'(rng[5:1])), 2'b00}, t);
      end
    end
    wait_drained();
    check("dmem_req_valid pulses", req_pulses - req0, 30);
    check("dmem_resp pulses", resp_pulses - resp0, 30);
    end_test("one outstanding access", err0);
  endtask

  task automatic flush_recovery();
    int err0;
    int mark;
    int occ;
    int n;
    lsu_pkg::rob_tag_t   t;
    lsu_pkg::store_req_t se;
    err0 = errors;
    wait_drained();
    alloc_load(10'h320, t);
    alloc_load(10'h324, t);
    alloc_load(10'h328, t);
    // one store per cycle; a store drains in two cycles at best, so the station fills
    occ = 0;  // store station occupancy from the next edge on
    n   = 0;
    @(negedge clk);
    while (occ < store_depth) begin
      @(posedge clk);
      book_store({8'(240 + n), 2'b00}, 32'hcafe0000 | 32'(n), 4'hf, se);  // top words are not read again
      store_alloc       <= 1'b1;
      store_alloc_entry <= se;
      n++;
      @(negedge clk);
      occ = occ + 1 - int'(store_done.valid);
    end
    @(posedge clk);
    store_alloc <= 1'b0;
    flush       <= 1'b1;
    @(posedge clk);
    flush      <= 1'b0;
    load_busy  = '0;  // whatever was still queued is gone
    store_busy = '0;
    loads_out  = 0;
    stores_out = 0;
    @(negedge clk);
    check("load_full", load_full, 0);
    check("store_full", store_full, 0);
    mark = done_pulses;
    while (dmem_busy) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    check("completions after flush", done_pulses - mark, 0);
    alloc_load(10'h324, t);
    wait_drained();
    check("load_done.tag", last_load_tag, t);
    check("load_done.rdata", last_load_data, ref_mem[201]);
    end_test("flush", err0);
  endtask

  // port rule, completions and both full levels, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      outstanding = 1'b0;
      full_prev   = 1'b0;
      load_cnt    = 0;
      store_cnt   = 0;
    end else begin
      if (flush && dmem_req_valid) begin
        flag_problem($sformatf("memory request granted during a flush at cycle %0d",
                               cycles));
      end
      if (dmem_req_valid) begin
        req_pulses++;
        req_we_log.push_back(dmem_req.we);
        if (outstanding && !dmem_resp) begin
          flag_problem($sformatf("second memory request at cycle %0d before a response",
                                 cycles));
        end
        if (!dmem_req.we) begin
          check("dmem_req.wmask", dmem_req.wmask, 0);
          check("dmem_req.wdata", dmem_req.wdata, 0);
        end
      end
      if (dmem_resp && outstanding) begin
        resp_pulses++;
      end
      outstanding = !flush && ((outstanding && !dmem_resp) || dmem_req_valid);

      if (load_done.valid) begin
        done_pulses++;
        last_load_tag  = load_done.tag;
        last_load_data = load_done.rdata;
        if (!load_busy[load_done.tag]) begin
          flag_problem($sformatf("load completed with tag %0d but none is outstanding",
                                 load_done.tag));
        end else begin
          check("load_done.rdata", load_done.rdata, load_exp[load_done.tag]);
          load_busy[load_done.tag] = 1'b0;
          loads_out--;
          loads_done_cnt++;
        end
      end
      if (store_done.valid) begin
        done_pulses++;
        last_store_tag = store_done.tag;
        if (!store_busy[store_done.tag]) begin
          flag_problem($sformatf("store completed with tag %0d but none is outstanding",
                                 store_done.tag));
        end else begin
          store_busy[store_done.tag] = 1'b0;
          stores_out--;
        end
      end

      check("load_full", load_full, load_cnt == load_depth);
      check("store_full", store_full, store_cnt == store_depth);
      if (load_full && !full_prev) begin
        full_rises++;
      end
      full_prev = load_full;
      if (flush) begin
        load_cnt  = 0;
        store_cnt = 0;
      end else begin
        load_cnt  = load_cnt + int'(load_alloc && load_cnt < load_depth)
                    - int'(load_done.valid);
        store_cnt = store_cnt + int'(store_alloc && store_cnt < store_depth)
                    - int'(store_done.valid);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    rst_n             = 1'b0;
    flush             = 1'b0;
    load_alloc        = 1'b0;
    load_alloc_entry  = '0;
    store_alloc       = 1'b0;
    store_alloc_entry = '0;
    load_busy         = '0;
    store_busy        = '0;
    rng               = 32'd36905;
    next_tag          = '0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = initial_word(i);
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    store_then_load();
    partial_writes();
    store_priority();
    many_loads();
    mixed_traffic();
    flush_recovery();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/lsu_pkg.sv
design/load_rs.sv
design/store_rs.sv
design/mem_arbiter_fsm.sv
design/load_store_unit.sv
tb/dmem_model.sv
tb/tb_load_store_unit.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module tb_load_store_unit -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
